// ==== hdl/scurve_cfg.svh ====
`ifndef SCURVE_CFG_SVH
`define SCURVE_CFG_SVH

// Discriminator channels and their counters
`define SC_NUM_CH   4
`define SC_CH_W     2
`define SC_CNT_W    16

// Threshold DAC code
`define SC_DAC_W    10

// Scan length and point index
`define SC_MAX_PTS  64
`define SC_PT_W     6
`define SC_NPTS_W   7

// One result word per point and channel
`define SC_RAM_AW   8

// Wishbone word address map
`define SC_ADR_W    9
`define SC_RES_BASE 256

// Trigger delay line depth
`define SC_TB_DLY   16

`endif

// ==== hdl/scurve_meas_pkg.sv ====
`include "scurve_cfg.svh"

package scurve_meas_pkg;

  // Trigger efficiency counts one fall per injection window
  typedef enum logic {
    COUNT_EFF = 1'b0,
    TRIG_EFF  = 1'b1
  } eff_mode_e;

  // Scan sequencer
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_START,
    SEQ_RUN,
    SEQ_DRAIN,
    SEQ_NEXT
  } seq_state_e;

  // Shared by all channels
  typedef struct packed {
    eff_mode_e            mode;
    logic [3:0]           trig_delay;
    logic [`SC_CNT_W-1:0] cpt_max;
  } chan_cfg_t;

  // Synchronized test pulse and its edges
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
  } inj_sync_t;

  // Result memory word
  typedef struct packed {
    logic [`SC_CNT_W-1:0] pulse_cnt;
    logic [`SC_CNT_W-1:0] trig_cnt;
  } result_rec_t;

endpackage

// ==== hdl/scurve_bus_pkg.sv ====
`include "scurve_cfg.svh"

package scurve_bus_pkg;

  import scurve_meas_pkg::*;

  // Wishbone classic, word addressed
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`SC_ADR_W-1:0] adr;
    logic [31:0]          dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Register word addresses
  typedef enum logic [2:0] {
    REG_CTRL      = 3'd0,
    REG_THR_START = 3'd1,
    REG_THR_STEP  = 3'd2,
    REG_NUM_PTS   = 3'd3,
    REG_CPT_MAX   = 3'd4,
    REG_TRIG_DLY  = 3'd5,
    REG_STATUS    = 3'd6
  } wb_reg_e;

  // Channel result write, held until granted
  typedef struct packed {
    logic                  req;
    logic [`SC_RAM_AW-1:0] addr;
    result_rec_t           data;
  } ram_wr_req_t;

  // Host readout
  typedef struct packed {
    logic                  req;
    logic [`SC_RAM_AW-1:0] addr;
  } ram_rd_req_t;

endpackage

// ==== hdl/scurve_channel.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module scurve_channel
  import scurve_meas_pkg::*, scurve_bus_pkg::*;
(
  input  logic                Clk,
  input  logic                reset_n,
  input  chan_cfg_t           cfg,
  input  inj_sync_t           inj,
  input  logic                start,
  input  logic                trigger,
  input  logic [`SC_PT_W-1:0] point,
  input  logic [`SC_CH_W-1:0] chan_idx,
  output ram_wr_req_t         wr,
  input  logic                grant,
  output logic                busy
);

  logic [`SC_TB_DLY-1:0] trig_sr;
  logic                  trig_tap;
  logic                  trig_q1;
  logic                  trig_q2;
  logic                  trig_fall;
  logic                  trig_en;
  logic                  active;
  logic                  arm;
  logic                  done;
  logic                  done_hit;
  logic                  wr_req;
  logic [`SC_CNT_W-1:0]  pulse_cnt;
  logic [`SC_CNT_W-1:0]  trig_cnt;

  //////////////////////////////////////////////////
  // Trigger delay and falling edge
  //////////////////////////////////////////////////

  // Delay line tap
  assign trig_tap = trig_sr[cfg.trig_delay];
  // Trigger efficiency only counts inside the injection window
  assign trig_en = active & ((cfg.mode == COUNT_EFF) | inj.level);
  assign trig_fall = ~trig_q1 & trig_q2;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_sr <= '1;
      trig_q1 <= 1'b1;
      trig_q2 <= 1'b1;
    end else begin
      trig_sr <= {trig_sr[`SC_TB_DLY-2:0], trigger};
      // Hold low after the first fall until the window closes
      if (cfg.mode == TRIG_EFF)
        trig_q1 <= (trig_tap & trig_q1) | ~trig_en;
      else
        trig_q1 <= trig_tap;
      trig_q2 <= trig_q1;
    end
  end

  //////////////////////////////////////////////////
  // Pulse and trigger counting
  //////////////////////////////////////////////////

  // Arm on the first rise after start, so a partial window is skipped
  assign arm = busy & ~active & (pulse_cnt == '0) & inj.rise;
  // Stop at the end of the window that reached cpt_max
  assign done_hit = active & inj.fall & (pulse_cnt >= cfg.cpt_max);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      busy      <= 1'b0;
      active    <= 1'b0;
      done      <= 1'b0;
      wr_req    <= 1'b0;
      pulse_cnt <= '0;
      trig_cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy      <= 1'b1;
        active    <= 1'b0;
        wr_req    <= 1'b0;
        pulse_cnt <= '0;
        trig_cnt  <= '0;
      end else begin
        if (arm)
          active <= 1'b1;
        if (arm || (active && inj.rise))
          pulse_cnt <= pulse_cnt + 1'b1;
        if (trig_fall && trig_en)
          trig_cnt <= trig_cnt + 1'b1;
        if (done_hit) begin
          active <= 1'b0;
          done   <= 1'b1;
        end
        // Request goes out the cycle after done
        if (done)
          wr_req <= 1'b1;
        if (grant) begin
          wr_req <= 1'b0;
          busy   <= 1'b0;
        end
      end
    end
  end

  // Word address is point * 4 + channel
  always_comb begin
    wr.req            = wr_req;
    wr.addr           = {point, chan_idx};
    wr.data.pulse_cnt = pulse_cnt;
    wr.data.trig_cnt  = trig_cnt;
  end

endmodule

// ==== hdl/scurve_sequencer.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module scurve_sequencer
  import scurve_meas_pkg::*;
(
  input  logic                  Clk,
  input  logic                  reset_n,
  input  logic                  go,
  input  logic [`SC_DAC_W-1:0]  thr_start,
  input  logic [`SC_DAC_W-1:0]  thr_step,
  input  logic [`SC_NPTS_W-1:0] num_pts,
  input  logic                  inj_pulse,
  input  logic [`SC_NUM_CH-1:0] busy,
  output inj_sync_t             inj,
  output logic                  start,
  output logic [`SC_PT_W-1:0]   point,
  output logic [`SC_DAC_W-1:0]  dac_threshold,
  output logic                  scan_busy,
  output logic                  scan_done
);

  seq_state_e            state;
  logic [2:0]            inj_sr;
  logic [`SC_NPTS_W-1:0] pts_lim;

  //////////////////////////////////////////////////
  // Test pulse synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n)
      inj_sr <= '0;
    else
      inj_sr <= {inj_sr[1:0], inj_pulse};
  end

  // Level after two flops, edges against the third
  always_comb begin
    inj.level = inj_sr[1];
    inj.rise  = inj_sr[1] & ~inj_sr[2];
    inj.fall  = ~inj_sr[1] & inj_sr[2];
  end

  //////////////////////////////////////////////////
  // Point stepping
  //////////////////////////////////////////////////

  assign start = (state == SEQ_START);

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= SEQ_IDLE;
      point         <= '0;
      pts_lim       <= '0;
      dac_threshold <= '0;
      scan_busy     <= 1'b0;
      scan_done     <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: if (go) begin
          scan_done <= 1'b0;
          point     <= '0;
          if (num_pts == '0) begin
            // Empty scan ends at once
            scan_done <= 1'b1;
          end else begin
            scan_busy <= 1'b1;
            pts_lim   <= (num_pts > `SC_MAX_PTS) ? `SC_NPTS_W'(`SC_MAX_PTS) : num_pts;
            state     <= SEQ_START;
          end
        end
        SEQ_START: begin
          // First point takes the start code
          if (point == '0)
            dac_threshold <= thr_start;
          state <= SEQ_RUN;
        end
        SEQ_RUN:
          if (|busy)
            state <= SEQ_DRAIN;
        SEQ_DRAIN:
          if (busy == '0) begin
            if ({1'b0, point} == pts_lim - 1'b1) begin
              scan_busy <= 1'b0;
              scan_done <= 1'b1;
              state     <= SEQ_IDLE;
            end else begin
              state <= SEQ_NEXT;
            end
          end
        SEQ_NEXT: begin
          point         <= point + 1'b1;
          dac_threshold <= dac_threshold + thr_step;
          state         <= SEQ_START;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/result_arbiter.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module result_arbiter
  import scurve_meas_pkg::*, scurve_bus_pkg::*;
(
  input  logic                  Clk,
  input  logic                  reset_n,
  input  ram_wr_req_t           wr [`SC_NUM_CH],
  input  ram_rd_req_t           rd,
  output logic [`SC_NUM_CH-1:0] wr_grant,
  output logic                  rd_grant,
  output logic                  ram_we,
  output logic [`SC_RAM_AW-1:0] ram_addr,
  output result_rec_t           ram_wdata
);

  // Channels first, host read in the top slot
  logic [`SC_NUM_CH:0] req;
  logic [`SC_NUM_CH:0] gnt;
  logic [`SC_CH_W:0]   ptr;
  logic [`SC_CH_W:0]   gnt_idx;

  always_comb begin
    for (int i = 0; i < `SC_NUM_CH; i++)
      req[i] = wr[i].req;
    req[`SC_NUM_CH] = rd.req;
  end

  // First requester at or after the pointer wins
  always_comb begin
    int idx;
    gnt     = '0;
    gnt_idx = ptr;
    for (int i = 0; i <= `SC_NUM_CH; i++) begin
      idx = int'(ptr) + i;
      if (idx > `SC_NUM_CH)
        idx = idx - (`SC_NUM_CH + 1);
      if (gnt == '0 && req[idx]) begin
        gnt[idx] = 1'b1;
        gnt_idx  = idx[`SC_CH_W:0];
      end
    end
  end

  // Winner drops to lowest priority
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n)
      ptr <= '0;
    else if (|gnt)
      ptr <= (gnt_idx == `SC_NUM_CH) ? '0 : gnt_idx + 1'b1;
  end

  assign wr_grant = gnt[`SC_NUM_CH-1:0];
  assign rd_grant = gnt[`SC_NUM_CH];

  // RAM port steering
  always_comb begin
    ram_we    = |wr_grant;
    ram_addr  = rd.addr;
    ram_wdata = '0;
    for (int i = 0; i < `SC_NUM_CH; i++)
      if (wr_grant[i]) begin
        ram_addr  = wr[i].addr;
        ram_wdata = wr[i].data;
      end
  end

endmodule

// ==== hdl/result_ram.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module result_ram
  import scurve_meas_pkg::*;
(
  input  logic                  Clk,
  input  logic                  we,
  input  logic [`SC_RAM_AW-1:0] addr,
  input  result_rec_t           wdata,
  output result_rec_t           rdata
);

  // One word per point and channel
  result_rec_t mem [2**`SC_RAM_AW];

  //////////////////////////////////////////////////
  // Single port, read data one cycle later
  //////////////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (we)
      mem[addr] <= wdata;
    // Read-first on a shared address
    rdata <= mem[addr];
  end

endmodule

// ==== hdl/scurve_wb_regs.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module scurve_wb_regs
  import scurve_meas_pkg::*, scurve_bus_pkg::*;
(
  input  logic                  Clk,
  input  logic                  reset_n,
  input  wb_req_t               wb_req,
  output wb_rsp_t               wb_rsp,
  output chan_cfg_t             cfg,
  output logic                  go,
  output logic [`SC_DAC_W-1:0]  thr_start,
  output logic [`SC_DAC_W-1:0]  thr_step,
  output logic [`SC_NPTS_W-1:0] num_pts,
  input  logic                  scan_busy,
  input  logic                  scan_done,
  output ram_rd_req_t           rd,
  input  logic                  rd_grant,
  input  result_rec_t           ram_rdata
);

  logic        access;
  logic        win_hit;
  logic        reg_hit;
  logic        new_acc;
  wb_reg_e     reg_sel;
  logic        reg_ack;
  logic        rd_pend;
  logic        rd_ack;
  logic [31:0] reg_dat;
  logic [31:0] rd_val;

  assign access  = wb_req.cyc & wb_req.stb;
  assign win_hit = (wb_req.adr >= `SC_RES_BASE);
  assign reg_hit = (wb_req.adr[`SC_ADR_W-1:3] == '0);
  assign reg_sel = wb_reg_e'(wb_req.adr[2:0]);
  // New cycle only once the previous one has been acked
  assign new_acc = access & ~(reg_ack | rd_pend | rd_ack);

  //////////////////////////////////////////////////
  // Register read mux
  //////////////////////////////////////////////////

  always_comb begin
    rd_val = '0;
    if (reg_hit)
      case (reg_sel)
        REG_CTRL:      rd_val[1] = cfg.mode;
        REG_THR_START: rd_val[`SC_DAC_W-1:0] = thr_start;
        REG_THR_STEP:  rd_val[`SC_DAC_W-1:0] = thr_step;
        REG_NUM_PTS:   rd_val[`SC_NPTS_W-1:0] = num_pts;
        REG_CPT_MAX:   rd_val[`SC_CNT_W-1:0] = cfg.cpt_max;
        REG_TRIG_DLY:  rd_val[3:0] = cfg.trig_delay;
        REG_STATUS:    rd_val[1:0] = {scan_done, scan_busy};
        default:       rd_val = '0;
      endcase
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      reg_ack   <= 1'b0;
      rd_pend   <= 1'b0;
      rd_ack    <= 1'b0;
      go        <= 1'b0;
      cfg       <= '0;
      thr_start <= '0;
      thr_step  <= '0;
      num_pts   <= '0;
      reg_dat   <= '0;
    end else begin
      go      <= 1'b0;
      reg_ack <= 1'b0;
      // RAM data shows up the cycle after the grant
      rd_ack  <= rd_grant;
      if (rd_grant)
        rd_pend <= 1'b0;
      if (new_acc) begin
        if (win_hit && !wb_req.we) begin
          rd_pend <= 1'b1;
        end else begin
          // Registers and window writes ack next cycle
          reg_ack <= 1'b1;
          reg_dat <= rd_val;
          if (wb_req.we && reg_hit)
            case (reg_sel)
              REG_CTRL:
                if (!scan_busy) begin
                  cfg.mode <= eff_mode_e'(wb_req.dat[1]);
                  go       <= wb_req.dat[0];
                end
              REG_THR_START: thr_start      <= wb_req.dat[`SC_DAC_W-1:0];
              REG_THR_STEP:  thr_step       <= wb_req.dat[`SC_DAC_W-1:0];
              REG_NUM_PTS:   num_pts        <= wb_req.dat[`SC_NPTS_W-1:0];
              REG_CPT_MAX:   cfg.cpt_max    <= wb_req.dat[`SC_CNT_W-1:0];
              REG_TRIG_DLY:  cfg.trig_delay <= wb_req.dat[3:0];
              default: ;
            endcase
        end
      end
    end
  end

  // Ack only inside an active cycle
  always_comb begin
    wb_rsp.ack = (reg_ack | rd_ack) & access;
    wb_rsp.dat = rd_ack ? ram_rdata : reg_dat;
    rd.req     = rd_pend;
    rd.addr    = wb_req.adr[`SC_RAM_AW-1:0];
  end

endmodule

// ==== hdl/scurve_top.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module scurve_top
  import scurve_meas_pkg::*, scurve_bus_pkg::*;
(
  input  logic                  Clk,
  input  logic                  reset_n,
  input  wb_req_t               wb_req,
  output wb_rsp_t               wb_rsp,
  input  logic                  inj_pulse,
  input  logic [`SC_NUM_CH-1:0] triggers,
  output logic [`SC_DAC_W-1:0]  dac_threshold
);

  chan_cfg_t             cfg;
  logic                  go;
  logic [`SC_DAC_W-1:0]  thr_start;
  logic [`SC_DAC_W-1:0]  thr_step;
  logic [`SC_NPTS_W-1:0] num_pts;
  logic                  scan_busy;
  logic                  scan_done;
  ram_rd_req_t           rd;
  logic                  rd_grant;
  inj_sync_t             inj;
  logic                  start;
  logic [`SC_PT_W-1:0]   point;
  logic [`SC_NUM_CH-1:0] busy;
  ram_wr_req_t           wr [`SC_NUM_CH];
  logic [`SC_NUM_CH-1:0] wr_grant;
  logic                  ram_we;
  logic [`SC_RAM_AW-1:0] ram_addr;
  result_rec_t           ram_wdata;
  result_rec_t           ram_rdata;

  //////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////

  scurve_wb_regs u_regs (
    .Clk, .reset_n, .wb_req, .wb_rsp, .cfg, .go, .thr_start, .thr_step,
    .num_pts, .scan_busy, .scan_done, .rd, .rd_grant, .ram_rdata
  );

  scurve_sequencer u_seq (
    .Clk, .reset_n, .go, .thr_start, .thr_step, .num_pts, .inj_pulse,
    .busy, .inj, .start, .point, .dac_threshold, .scan_busy, .scan_done
  );

  //////////////////////////////////////////////////
  // Channels and result memory
  //////////////////////////////////////////////////

  for (genvar i = 0; i < `SC_NUM_CH; i++) begin : g_ch
    scurve_channel u_ch (
      .Clk, .reset_n, .cfg, .inj, .start, .point,
      .trigger  (triggers[i]),
      .chan_idx (`SC_CH_W'(i)),
      .wr       (wr[i]),
      .grant    (wr_grant[i]),
      .busy     (busy[i])
    );
  end

  result_arbiter u_arb (
    .Clk, .reset_n, .wr, .rd, .wr_grant, .rd_grant, .ram_we, .ram_addr, .ram_wdata
  );

  result_ram u_ram (
    .Clk, .we (ram_we), .addr (ram_addr), .wdata (ram_wdata), .rdata (ram_rdata)
  );

endmodule

// ==== dv/scurve_chk.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module scurve_chk
  import scurve_meas_pkg::*, scurve_bus_pkg::*;
(
  input  logic                  Clk,
  input  logic                  reset_n,
  input  wb_req_t               wb_req,
  input  wb_rsp_t               wb_rsp,
  input  logic                  start,
  input  logic [`SC_NUM_CH-1:0] busy,
  input  ram_wr_req_t           wr [`SC_NUM_CH],
  input  logic [`SC_NUM_CH-1:0] wr_grant,
  input  ram_rd_req_t           rd,
  input  logic                  rd_grant,
  input  logic [`SC_DAC_W-1:0]  dac_threshold,
  input  logic [`SC_DAC_W-1:0]  thr_start,
  input  logic [`SC_DAC_W-1:0]  thr_step,
  input  logic [`SC_PT_W-1:0]   point,
  input  seq_state_e            seq_state
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // Channels low, host read in the top bit
  logic [`SC_NUM_CH:0] req_vec;
  logic [`SC_NUM_CH:0] gnt_vec;
  logic                quiet;

  always_comb begin
    for (int i = 0; i < `SC_NUM_CH; i++)
      req_vec[i] = wr[i].req;
    req_vec[`SC_NUM_CH] = rd.req;
  end

  assign gnt_vec = {rd_grant, wr_grant};
  assign quiet   = !wb_rsp.ack && !start && (busy == '0) && (gnt_vec == '0) &&
                   (dac_threshold == '0);

  //////////////////////////////////////////////////
  // Reset state
  //////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge Clk) !reset_n |-> quiet)
    else begin fail_cnt++; $error("Outputs active during reset"); end

  a_reset_exit: assert property (@(posedge Clk) $rose(reset_n) |-> quiet)
    else begin fail_cnt++; $error("Outputs active right after reset"); end

  //////////////////////////////////////////////////
  // Threshold stepping
  //////////////////////////////////////////////////

  // Load of the start code for point 0, otherwise one step in SEQ_NEXT
  a_thr_step: assert property (@(posedge Clk) disable iff (!reset_n)
    (dac_threshold != $past(dac_threshold)) |->
      (($past(seq_state) == SEQ_NEXT) &&
       (dac_threshold == $past(dac_threshold + thr_step))) ||
      (($past(seq_state) == SEQ_START) && ($past(point) == '0) &&
       (dac_threshold == $past(thr_start))))
    else begin fail_cnt++; $error("Threshold changed outside a point step"); end

  //////////////////////////////////////////////////
  // Arbiter
  //////////////////////////////////////////////////

  a_gnt_onehot: assert property (@(posedge Clk) disable iff (!reset_n) $onehot0(gnt_vec))
    else begin fail_cnt++; $error("More than one grant in a cycle"); end

  a_gnt_req: assert property (@(posedge Clk) disable iff (!reset_n)
    (gnt_vec & ~req_vec) == '0)
    else begin fail_cnt++; $error("Grant without a request"); end

  // Five requesters, so no one waits more than four cycles
  for (genvar i = 0; i <= `SC_NUM_CH; i++) begin : g_fair
    a_gnt_wait: assert property (@(posedge Clk) disable iff (!reset_n)
      req_vec[i] |-> ##[0:4] gnt_vec[i])
      else begin fail_cnt++; $error("Request %0d not granted in time", i); end
  end

  //////////////////////////////////////////////////
  // Wishbone ack
  //////////////////////////////////////////////////

  a_ack_cycle: assert property (@(posedge Clk) disable iff (!reset_n)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else begin fail_cnt++; $error("Ack outside a bus cycle"); end

  a_ack_pulse: assert property (@(posedge Clk) disable iff (!reset_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin fail_cnt++; $error("Ack longer than one cycle"); end

endmodule

// ==== dv/scurve_tb.sv ====
`timescale 1ns/1ps
`include "scurve_cfg.svh"

module scurve_tb
  import scurve_meas_pkg::*, scurve_bus_pkg::*;
();

  localparam time DRV          = 5;
  localparam int  BUS_TIMEOUT  = 20;
  localparam int  STATUS_POLLS = 3000;
  // Injection wave, 10 cycles high then 10 low
  localparam int  INJ_PERIOD   = 20;
  localparam int  INJ_HIGH     = 10;
  // Scan setup
  localparam int  NUM_PTS      = 8;
  localparam int  THR_START    = 100;
  localparam int  THR_STEP     = 20;
  localparam int  PED_MIN      = 90;
  localparam int  PED_SPAN     = 180;

  logic                  Clk;
  logic                  reset_n;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  logic                  inj_pulse;
  logic [`SC_NUM_CH-1:0] triggers;
  logic [`SC_DAC_W-1:0]  dac_threshold;
  logic [`SC_DAC_W-1:0]  pedestal [`SC_NUM_CH];
  int                    inj_phase;

  scurve_top u_dut (
    .Clk, .reset_n, .wb_req, .wb_rsp, .inj_pulse, .triggers, .dac_threshold
  );

  bind scurve_top scurve_chk u_chk (
    .Clk, .reset_n, .wb_req, .wb_rsp, .start, .busy, .wr, .wr_grant, .rd,
    .rd_grant, .dac_threshold, .thr_start, .thr_step, .point,
    .seq_state (u_seq.state)
  );

  initial begin
    Clk = 1'b0;
    forever #50 Clk = ~Clk;
  end

  //////////////////////////////////////////////////
  // Test pulse and discriminator models
  //////////////////////////////////////////////////

  // Two 1-cycle falls per window while below the pedestal
  always @(posedge Clk) begin
    #DRV;
    inj_phase = (inj_phase == INJ_PERIOD - 1) ? 0 : inj_phase + 1;
    inj_pulse = (inj_phase < INJ_HIGH);
    for (int c = 0; c < `SC_NUM_CH; c++)
      triggers[c] = !((inj_phase == 2 || inj_phase == 5) && (dac_threshold < pedestal[c]));
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Stop at the first failed bound assertion
  always @(posedge Clk)
    if (u_dut.u_chk.fail_cnt != 0)
      fail_run("A bound checker assertion failed");

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                            $time, name, got, exp));
  endtask

  //////////////////////////////////////////////////
  // Host bus
  //////////////////////////////////////////////////

  task automatic bus_cycle(input logic we, input logic [`SC_ADR_W-1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int cycles;
    cycles = 0;
    rdat   = '0;
    @(posedge Clk);
    #DRV;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    @(negedge Clk);
    while (!wb_rsp.ack && cycles < BUS_TIMEOUT) begin
      cycles++;
      @(negedge Clk);
    end
    if (!wb_rsp.ack) begin
      fail_run($sformatf("No ack for bus cycle at word address %0d", adr));
    end else begin
      rdat = wb_rsp.dat;
      // Ack counted at this edge
      @(posedge Clk);
      #DRV;
      wb_req = '0;
    end
  endtask

  task automatic reg_write(input wb_reg_e r, input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, `SC_ADR_W'(r), dat, unused);
  endtask

  task automatic reg_read(input wb_reg_e r, output logic [31:0] dat);
    bus_cycle(1'b0, `SC_ADR_W'(r), '0, dat);
  endtask

  task automatic reg_check(input wb_reg_e r, input logic [31:0] exp, input string name);
    logic [31:0] dat;
    reg_read(r, dat);
    check_val(name, dat, exp);
  endtask

  // Status bits are {done, busy}
  task automatic wait_status(input logic [1:0] want);
    logic [31:0] st;
    int          polls;
    polls = 0;
    reg_read(REG_STATUS, st);
    while (st[1:0] !== want && polls < STATUS_POLLS) begin
      polls++;
      reg_read(REG_STATUS, st);
    end
    if (st[1:0] !== want)
      fail_run($sformatf("Status stuck at %b while waiting for %b", st[1:0], want));
  endtask

  //////////////////////////////////////////////////
  // One full scan and its readout
  //////////////////////////////////////////////////

  task automatic run_scan(input eff_mode_e mode);
    logic [31:0]          rdat;
    logic [`SC_DAC_W-1:0] thr;
    int unsigned          cpt_max;
    int unsigned          trig_dly;
    int unsigned          exp_trig;
    cpt_max  = $urandom_range(8, 3);
    trig_dly = $urandom_range(3, 0);
    for (int c = 0; c < `SC_NUM_CH; c++)
      pedestal[c] = `SC_DAC_W'(PED_MIN + $urandom_range(PED_SPAN, 0));
    reg_write(REG_THR_START, 32'(THR_START));
    reg_write(REG_THR_STEP, 32'(THR_STEP));
    reg_write(REG_NUM_PTS, 32'(NUM_PTS));
    reg_write(REG_CPT_MAX, cpt_max);
    reg_write(REG_TRIG_DLY, trig_dly);
    reg_check(REG_THR_START, 32'(THR_START), "thr_start");
    reg_check(REG_THR_STEP, 32'(THR_STEP), "thr_step");
    reg_check(REG_NUM_PTS, 32'(NUM_PTS), "num_pts");
    reg_check(REG_CPT_MAX, cpt_max, "cpt_max");
    reg_check(REG_TRIG_DLY, trig_dly, "trig_delay");
    // Go with the mode in bit 1
    reg_write(REG_CTRL, 32'({mode, 1'b1}));
    reg_check(REG_CTRL, 32'({mode, 1'b0}), "ctrl_mode");
    wait_status(2'b01);
    // Second go with the other mode is dropped while busy
    reg_write(REG_CTRL, 32'({~mode, 1'b1}));
    reg_check(REG_CTRL, 32'({mode, 1'b0}), "ctrl_mode_busy");
    wait_status(2'b10);
    for (int p = 0; p < NUM_PTS; p++) begin
      thr = `SC_DAC_W'(THR_START + p * THR_STEP);
      for (int c = 0; c < `SC_NUM_CH; c++) begin
        bus_cycle(1'b0, `SC_ADR_W'(`SC_RES_BASE + p * `SC_NUM_CH + c), '0, rdat);
        if (thr < pedestal[c])
          exp_trig = (mode == COUNT_EFF) ? 2 * cpt_max : cpt_max;
        else
          exp_trig = 0;
        check_val($sformatf("pulse_cnt[%0d][%0d]", p, c), 32'(rdat[31:16]), cpt_max);
        check_val($sformatf("trig_cnt[%0d][%0d]", p, c), 32'(rdat[15:0]), exp_trig);
      end
    end
  endtask

  initial begin
    void'($urandom(32'he97b_902b));
    reset_n   = 1'b0;
    wb_req    = '0;
    inj_pulse = 1'b0;
    triggers  = '1;
    inj_phase = 0;
    for (int c = 0; c < `SC_NUM_CH; c++)
      pedestal[c] = '0;
    repeat (4) @(posedge Clk);
    #DRV;
    reset_n = 1'b1;
    run_scan(COUNT_EFF);
    run_scan(TRIG_EFF);
    if (u_dut.u_chk.fail_cnt != 0) begin
      fail_run("A bound checker assertion failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/scurve_meas_pkg.sv
hdl/scurve_bus_pkg.sv
hdl/scurve_channel.sv
hdl/scurve_sequencer.sv
hdl/result_arbiter.sv
hdl/result_ram.sv
hdl/scurve_wb_regs.sv
hdl/scurve_top.sv
dv/scurve_chk.sv
dv/scurve_tb.sv
